/* src/fifo_pkg.sv */
package fifo_pkg;

  // ------------------------------------------------
  // FIFO geometry
  // ------------------------------------------------

  // Number of entries in the flop array
  localparam int depth = 8;
  // Payload width
  localparam int data_width = 8;
  // Enough bits to index 0 to depth-1
  localparam int addr_width = 3;
  // Enough bits to hold 0 to depth
  localparam int count_width = 4;

  // Widths with a meaning
  typedef logic [data_width-1:0]  fifo_data_t;
  typedef logic [addr_width-1:0]  fifo_addr_t;
  typedef logic [count_width-1:0] fifo_count_t;

  // Write request into the flop array, 12 bits
  typedef struct packed {
    logic       valid;
    fifo_addr_t addr;
    fifo_data_t data;
  } fifo_ram_wr_t;

  // Read request into the flop array, 4 bits
  typedef struct packed {
    logic       valid;
    fifo_addr_t addr;
  } fifo_ram_rd_t;

endpackage

/* src/fifo_flop_ram.sv */
`timescale 1ns/1ns

module fifo_flop_ram (
  input  logic                   clk,
  input  logic                   rst_n,

  // Registered write port
  input  fifo_pkg::fifo_ram_wr_t ram_wr,

  // Combinational read port
  input  fifo_pkg::fifo_ram_rd_t ram_rd,
  output fifo_pkg::fifo_data_t   ram_rd_data
);

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------

  // One flop row per entry
  fifo_pkg::fifo_data_t mem [fifo_pkg::depth];

  // Rows cleared on reset and one row written per edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < fifo_pkg::depth; i++) begin
        mem[i] <= '0;
      end
    end else if (ram_wr.valid) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // ------------------------------------------------
  // Read
  // ------------------------------------------------

  // Zero latency with data following the address in the same cycle
  assign ram_rd_data = mem[ram_rd.addr];

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------

  // Head being read and slot being written never coincide
  no_rd_wr_collision_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    (ram_wr.valid && ram_rd.valid) |-> (ram_wr.addr != ram_rd.addr)
  );

endmodule

/* src/fifo_push_ctrl.sv */
`timescale 1ns/1ns

module fifo_push_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,

  // Push port
  input  logic                   push_valid,
  input  fifo_pkg::fifo_data_t   push_data,
  output logic                   push_ready,

  // Push side status
  output logic                   full,
  output fifo_pkg::fifo_count_t  slots,

  // Bypass path toward the pop controller
  input  logic                   bypass_ready,
  output logic                   bypass_valid,
  output fifo_pkg::fifo_data_t   bypass_data,

  // Write port of the flop array
  output fifo_pkg::fifo_ram_wr_t ram_wr,

  // Handshakes with the pop controller
  output logic                   ram_push,
  input  logic                   ram_pop
);

  // ------------------------------------------------
  // Flow control
  // ------------------------------------------------

  logic                  push;
  fifo_pkg::fifo_addr_t  wr_addr;
  fifo_pkg::fifo_count_t slots_next;

  // Ready straight off the registered flag
  assign push_ready = !full;
  assign push       = push_valid && push_ready;

  // Offer every push to the pop side
  assign bypass_valid = push_valid;
  assign bypass_data  = push_data;

  // Only pushes the pop side did not take land in the array
  assign ram_push = push && !bypass_ready;

  // ------------------------------------------------
  // Write address
  // ------------------------------------------------

  // Wraps at depth-1
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (ram_push) begin
      if (wr_addr == fifo_pkg::fifo_addr_t'(fifo_pkg::depth - 1)) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // Write request takes its data straight from the push port
  assign ram_wr = '{valid: ram_push, addr: wr_addr, data: push_data};

  // ------------------------------------------------
  // Slot count and full flag
  // ------------------------------------------------

  // Push alone takes a slot and pop alone frees one
  always_comb begin
    slots_next = slots;
    if (ram_push && !ram_pop) begin
      slots_next = slots - 1'b1;
    end else if (!ram_push && ram_pop) begin
      slots_next = slots + 1'b1;
    end
  end

  // Both update on the same edge as the pop side counts
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slots <= fifo_pkg::fifo_count_t'(fifo_pkg::depth);
      full  <= 1'b0;
    end else if (ram_push || ram_pop) begin
      slots <= slots_next;
      // Full from the next count so ready drops right on the last write
      full  <= (slots_next == '0);
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------

  // Nothing may be written once the slot count reaches zero
  no_ram_push_when_full_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    (slots == '0) |-> !ram_push
  );

  // Pops from the other side can never free more than depth
  slots_in_range_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    slots <= fifo_pkg::depth
  );

endmodule

/* src/fifo_pop_ctrl.sv */
`timescale 1ns/1ns

module fifo_pop_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,

  // Pop port
  input  logic                   pop_ready,
  output logic                   pop_valid,
  output fifo_pkg::fifo_data_t   pop_data,

  // Bypass path from the push controller
  output logic                   bypass_ready,
  input  logic                   bypass_valid,
  input  fifo_pkg::fifo_data_t   bypass_data,

  // Read port of the flop array
  output fifo_pkg::fifo_ram_rd_t ram_rd,
  input  fifo_pkg::fifo_data_t   ram_rd_data,

  // Handshakes with the push controller
  input  logic                   ram_push,
  output logic                   ram_pop,

  // Pop side status
  output logic                   empty,
  output fifo_pkg::fifo_count_t  items
);

  // ------------------------------------------------
  // Flow control
  // ------------------------------------------------

  logic                  pop;
  fifo_pkg::fifo_addr_t  rd_addr;
  fifo_pkg::fifo_count_t items_next;

  assign pop = pop_valid && pop_ready;

  // Take pushes directly only with nothing stored
  assign bypass_ready = empty && pop_ready;

  // Stored head or a push passing through
  assign pop_valid = !empty || bypass_valid;
  assign pop_data  = empty ? bypass_data : ram_rd_data;

  // Anything popped while not empty comes from the array
  assign ram_pop = pop && !empty;

  // ------------------------------------------------
  // Read address
  // ------------------------------------------------

  // Same wrap as the write side
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr <= '0;
    end else if (ram_pop) begin
      if (rd_addr == fifo_pkg::fifo_addr_t'(fifo_pkg::depth - 1)) begin
        rd_addr <= '0;
      end else begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  // Combinational read keeps the head on ram_rd_data
  assign ram_rd = '{valid: ram_pop, addr: rd_addr};

  // ------------------------------------------------
  // Item count and empty flag
  // ------------------------------------------------

  // Simultaneous push and pop leave the count alone
  always_comb begin
    items_next = items;
    if (ram_push && !ram_pop) begin
      items_next = items + 1'b1;
    end else if (!ram_push && ram_pop) begin
      items_next = items - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      items <= '0;
      empty <= 1'b1;
    end else if (ram_push || ram_pop) begin
      items <= items_next;
      empty <= (items_next == '0);
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------

  items_in_range_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    items <= fifo_pkg::depth
  );

  // Two separate registers must agree
  empty_matches_items_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    empty == (items == '0)
  );

  // Push side must stop writing once the array holds depth items
  no_ram_push_when_all_items_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    (items == fifo_pkg::fifo_count_t'(fifo_pkg::depth)) |-> !ram_push
  );

  // A push taken through bypass never lands in the array
  no_ram_push_on_bypass_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    bypass_ready |-> !ram_push
  );

endmodule

/* src/fifo_flops.sv */
`timescale 1ns/1ns

module fifo_flops (
  input  logic                  clk,
  input  logic                  rst_n,

  // Push port
  input  logic                  push_valid,
  input  fifo_pkg::fifo_data_t  push_data,
  output logic                  push_ready,

  // Push side status
  output logic                  full,
  output fifo_pkg::fifo_count_t slots,

  // Pop port
  input  logic                  pop_ready,
  output logic                  pop_valid,
  output fifo_pkg::fifo_data_t  pop_data,

  // Pop side status
  output logic                  empty,
  output fifo_pkg::fifo_count_t items
);

  // ------------------------------------------------
  // Internal wiring
  // ------------------------------------------------

  // Array ports
  fifo_pkg::fifo_ram_wr_t ram_wr;
  fifo_pkg::fifo_ram_rd_t ram_rd;
  fifo_pkg::fifo_data_t   ram_rd_data;

  // Controller handshakes
  logic ram_push;
  logic ram_pop;

  // Bypass path
  logic                 bypass_ready;
  logic                 bypass_valid;
  fifo_pkg::fifo_data_t bypass_data;

  // ------------------------------------------------
  // Instances
  // ------------------------------------------------

  fifo_push_ctrl i_fifo_push_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .push_ready   (push_ready),
    .full         (full),
    .slots        (slots),
    .bypass_ready (bypass_ready),
    .bypass_valid (bypass_valid),
    .bypass_data  (bypass_data),
    .ram_wr       (ram_wr),
    .ram_push     (ram_push),
    .ram_pop      (ram_pop)
  );

  fifo_pop_ctrl i_fifo_pop_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .pop_ready    (pop_ready),
    .pop_valid    (pop_valid),
    .pop_data     (pop_data),
    .bypass_ready (bypass_ready),
    .bypass_valid (bypass_valid),
    .bypass_data  (bypass_data),
    .ram_rd       (ram_rd),
    .ram_rd_data  (ram_rd_data),
    .ram_push     (ram_push),
    .ram_pop      (ram_pop),
    .empty        (empty),
    .items        (items)
  );

  // Shared storage between the two sides
  fifo_flop_ram i_fifo_flop_ram (
    .clk          (clk),
    .rst_n        (rst_n),
    .ram_wr       (ram_wr),
    .ram_rd       (ram_rd),
    .ram_rd_data  (ram_rd_data)
  );

endmodule

/* include/fifo_tb_util.svh */
`ifndef FIFO_TB_UTIL_SVH
`define FIFO_TB_UTIL_SVH

// ------------------------------------------------
// Payload generation
// ------------------------------------------------

// Starting state of the payload LFSR
function automatic logic [15:0] lfsr_seed();
  return 16'd10926;
endfunction

// 16 bit Galois LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
  logic [15:0] next_state;
  next_state = state >> 1;
  if (state[0]) begin
    next_state = next_state ^ 16'hB400;
  end
  return next_state;
endfunction

// One step per payload bit, lsb first
function automatic fifo_pkg::fifo_data_t lfsr_payload(inout logic [15:0] state);
  fifo_pkg::fifo_data_t payload;
  payload = '0;
  for (int i = 0; i < fifo_pkg::data_width; i++) begin
    payload[i] = state[0];
    state      = lfsr_step(state);
  end
  return payload;
endfunction

// ------------------------------------------------
// Failure handling and compares
// ------------------------------------------------

// Report, mark the run failed and stop
task automatic fail_test(input string msg);
  $display("%s", msg);
  $display("TEST FAIL");
  $fatal(1, "%s", msg);
endtask

task automatic check_data(input string name, input fifo_pkg::fifo_data_t expected,
                          input fifo_pkg::fifo_data_t actual);
  if (actual !== expected) begin
    fail_test($sformatf("FAILED at %0t: %s expected 0x%02h actual 0x%02h",
                        $time, name, expected, actual));
  end
endtask

task automatic check_count(input string name, input fifo_pkg::fifo_count_t expected,
                           input fifo_pkg::fifo_count_t actual);
  if (actual !== expected) begin
    fail_test($sformatf("FAILED at %0t: %s expected %0d actual %0d",
                        $time, name, expected, actual));
  end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    fail_test($sformatf("FAILED at %0t: %s expected %b actual %b",
                        $time, name, expected, actual));
  end
endtask

`endif

/* tb/fifo_flops_tb.sv */
`timescale 1ns/1ns

module fifo_flops_tb;

  // ------------------------------------------------
  // DUT signals
  // ------------------------------------------------

  logic                  clk;
  logic                  rst_n;
  logic                  push_valid;
  fifo_pkg::fifo_data_t  push_data;
  logic                  push_ready;
  logic                  full;
  fifo_pkg::fifo_count_t slots;
  logic                  pop_ready;
  logic                  pop_valid;
  fifo_pkg::fifo_data_t  pop_data;
  logic                  empty;
  fifo_pkg::fifo_count_t items;

  // One table row holds enables, length and items expected after the row
  typedef struct packed {
    logic                  push_en;
    logic                  pop_en;
    logic [7:0]            reps;
    fifo_pkg::fifo_count_t exp_items;
  } stim_row_t;

  localparam int num_rows = 9;

  // Bypass, fill past full, hold, half drain, steady traffic, hold, drain, refill, drain
  stim_row_t stim_table [num_rows] = '{
    '{1'b1, 1'b1, 8'd4,  4'd0},
    '{1'b1, 1'b0, 8'd10, 4'd8},
    '{1'b0, 1'b0, 8'd3,  4'd8},
    '{1'b0, 1'b1, 8'd4,  4'd4},
    '{1'b1, 1'b1, 8'd6,  4'd4},
    '{1'b0, 1'b0, 8'd2,  4'd4},
    '{1'b0, 1'b1, 8'd6,  4'd0},
    '{1'b1, 1'b0, 8'd3,  4'd3},
    '{1'b0, 1'b1, 8'd3,  4'd0}
  };

  // Reference queue of accepted payloads with the head first
  fifo_pkg::fifo_data_t  ref_q [$];
  logic [15:0]           lfsr_state;
  int                    cycle_count = 0;
  int                    timeout_limit;
  logic                  row_check_due;
  fifo_pkg::fifo_count_t row_items_exp;

  `include "fifo_tb_util.svh"

  fifo_flops i_fifo_flops (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .full       (full),
    .slots      (slots),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .empty      (empty),
    .items      (items)
  );

  // ------------------------------------------------
  // Clock and run limit
  // ------------------------------------------------

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      fail_test("timeout: table did not complete");
    end
  end

  // Total table length in cycles
  function automatic int table_cycles();
    int total;
    total = 0;
    for (int r = 0; r < num_rows; r++) begin
      total += stim_table[r].reps;
    end
    return total;
  endfunction

  // ------------------------------------------------
  // Per cycle drive, check and model update
  // ------------------------------------------------

  // Outputs checked at the falling edge against the queue before this cycle's transfers
  task automatic check_outputs();
    int                   size;
    logic                 exp_pop_valid;
    logic                 exp_ready;
    fifo_pkg::fifo_data_t exp_head;
    size          = ref_q.size();
    exp_ready     = (size < fifo_pkg::depth);
    exp_pop_valid = (size > 0) || push_valid;
    exp_head      = (size > 0) ? ref_q[0] : push_data;
    // Sum of both sides always adds up to depth
    check_count("items + slots", fifo_pkg::fifo_count_t'(fifo_pkg::depth), items + slots);
    check_count("items", fifo_pkg::fifo_count_t'(size), items);
    check_count("slots", fifo_pkg::fifo_count_t'(fifo_pkg::depth - size), slots);
    check_flag("empty", size == 0, empty);
    check_flag("full", !exp_ready, full);
    check_flag("push_ready", exp_ready, push_ready);
    check_flag("pop_valid", exp_pop_valid, pop_valid);
    // Holds the head steady under back-pressure too
    if (exp_pop_valid) begin
      check_data("pop_data", exp_head, pop_data);
    end
    // Push goes in before the pop so bypass pops its own data
    if (push_valid && exp_ready) begin
      ref_q.push_back(push_data);
    end
    if (pop_ready && exp_pop_valid) begin
      void'(ref_q.pop_front());
    end
  endtask

  task automatic run_cycle(input logic push_en, input logic pop_en);
    fifo_pkg::fifo_data_t payload;
    @(posedge clk);
    if (push_en) begin
      payload = lfsr_payload(lfsr_state);
      push_data <= payload;
    end
    push_valid <= push_en;
    pop_ready  <= pop_en;
    @(negedge clk);
    // Count of the previous row has settled one edge later
    if (row_check_due) begin
      check_count("items at row end", row_items_exp, items);
      row_check_due = 1'b0;
    end
    check_outputs();
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    push_valid    = 1'b0;
    push_data     = '0;
    pop_ready     = 1'b0;
    row_check_due = 1'b0;
    row_items_exp = '0;
    lfsr_state    = lfsr_seed();
    timeout_limit = table_cycles() + 8 + 20;

    // Reset for 8 cycles
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("empty", 1'b1, empty);
    check_flag("full", 1'b0, full);
    check_count("items", '0, items);
    check_count("slots", fifo_pkg::fifo_count_t'(fifo_pkg::depth), slots);
    check_flag("push_ready", 1'b1, push_ready);
    check_flag("pop_valid", 1'b0, pop_valid);

    for (int r = 0; r < num_rows; r++) begin
      for (int c = 0; c < stim_table[r].reps; c++) begin
        run_cycle(stim_table[r].push_en, stim_table[r].pop_en);
      end
      row_items_exp = stim_table[r].exp_items;
      row_check_due = 1'b1;
    end
    // Idle cycle picks up the last row's count
    run_cycle(1'b0, 1'b0);

    $display("TEST PASS");
    $finish;
  end

endmodule

/* build.f */
+incdir+include
src/fifo_pkg.sv
src/fifo_flop_ram.sv
src/fifo_push_ctrl.sv
src/fifo_pop_ctrl.sv
src/fifo_flops.sv
tb/fifo_flops_tb.sv

/* Bender.yml */
package:
  name: fifo_flops

sources:
  # Package first, the RTL refers to it by scope
  - files:
      - src/fifo_pkg.sv
  - files:
      - src/fifo_flop_ram.sv
      - src/fifo_push_ctrl.sv
      - src/fifo_pop_ctrl.sv
      - src/fifo_flops.sv

  # Testbench with its included helper header
  - target: test
    include_dirs:
      - include
    files:
      - tb/fifo_flops_tb.sv
